/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_store_queue
FLIST     ?= store_queue_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/apb_mem_model.sv */
`timescale 1ns/1ps

module apb_mem_model (
    input  logic clk,
    input  logic arst_n,
    input  logic psel,
    input  logic penable,
    input  logic stall,        // Wait state request from the falling edge
    input  int   err_index,    // Write number that answers with pslverr
    output logic pready,
    output logic pslverr,
    output int   write_count
);

    assign pready  = psel && penable && !stall;
    assign pslverr = pready && (write_count == err_index);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_count <= 0;
        end else if (pready) begin
            write_count <= write_count + 1;  // One per finished write
        end
    end

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period = 20  // 40 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

/* bench/sq_checker.sv */
`timescale 1ns/1ps

module sq_checker #(
    parameter int sq_depth = 8
) (
    input logic                clk,
    input logic                arst_n,
    input logic                st_valid,
    input logic                st_ready,
    input lsu_pkg::store_req_t st_req,
    input logic                ld_valid,
    input lsu_pkg::load_req_t  ld_req,
    input logic                ld_resp_valid,
    input lsu_pkg::load_resp_t ld_resp,
    input logic                commit_valid,
    input logic                flush,
    input lsu_pkg::addr_t      paddr,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input lsu_pkg::word_t      pwdata,
    input lsu_pkg::byte_mask_t pstrb,
    input logic                pready,
    input logic                pslverr,
    input logic                drain_error
);

    lsu_pkg::sq_store_t  model_q [$];  // Program order with the oldest first
    int                  cmt_left;     // Committed and not yet written
    int                  errors;
    int                  checks;
    bit                  err_seen;
    bit                  ld_pend;
    lsu_pkg::load_req_t  ld_hold;
    bit                  exp_pend;
    lsu_pkg::load_resp_t exp_resp;
    bit                  prev_psel;
    bit                  prev_penable;
    bit                  prev_pready;
    lsu_pkg::addr_t      prev_paddr;
    lsu_pkg::word_t      prev_pwdata;
    lsu_pkg::byte_mask_t prev_pstrb;

    function automatic int lane_of(lsu_pkg::addr_t a, lsu_pkg::mem_size_t s);
        if (s == lsu_pkg::size_byte || s == lsu_pkg::size_byte_u) return int'(a[1:0]);
        if (s == lsu_pkg::size_half || s == lsu_pkg::size_half_u) return a[1] ? 2 : 0;
        return 0;
    endfunction

    function automatic lsu_pkg::byte_mask_t need_of(lsu_pkg::mem_size_t s, int lane);
        if (s == lsu_pkg::size_byte || s == lsu_pkg::size_byte_u) return 4'b0001 << lane;
        if (s == lsu_pkg::size_half || s == lsu_pkg::size_half_u) return 4'b0011 << lane;
        return 4'b1111;
    endfunction

    function automatic lsu_pkg::sq_store_t place_store(lsu_pkg::store_req_t r);
        lsu_pkg::sq_store_t e;
        lsu_pkg::word_t     keep;
        int                 lane;
        lane = lane_of(r.addr, r.size);
        e.tag = r.tag;
        e.waddr = r.addr[31:2];
        e.byte_mask = need_of(r.size, lane);
        keep = (r.size == lsu_pkg::size_word) ? 32'hffff_ffff :
               (e.byte_mask[lane+1] && lane < 3) ? 32'h0000_ffff : 32'h0000_00ff;
        e.data = (r.data & keep) << (8 * lane);
        return e;
    endfunction

    // Older stores only and the youngest wins per lane
    function automatic lsu_pkg::load_resp_t expect_load(lsu_pkg::load_req_t r);
        lsu_pkg::load_resp_t res;
        lsu_pkg::word_t      fwd;
        lsu_pkg::byte_mask_t got;
        lsu_pkg::byte_mask_t need;
        lsu_pkg::seq_tag_t   diff;
        lsu_pkg::word_t      v;
        int                  lane;
        fwd = '0;
        got = '0;
        lane = lane_of(r.addr, r.size);
        need = need_of(r.size, lane);
        foreach (model_q[i]) begin
            diff = model_q[i].tag - r.tag;
            if (model_q[i].waddr == r.addr[31:2] && diff[7]) begin
                for (int b = 0; b < 4; b++) begin
                    if (model_q[i].byte_mask[b]) begin
                        fwd[8*b +: 8] = model_q[i].data[8*b +: 8];
                        got[b] = 1'b1;
                    end
                end
            end
        end
        v = fwd >> (8 * lane);
        case (r.size)
            lsu_pkg::size_byte:   res.data = {{24{v[7]}}, v[7:0]};
            lsu_pkg::size_byte_u: res.data = {24'h0, v[7:0]};
            lsu_pkg::size_half:   res.data = {{16{v[15]}}, v[15:0]};
            lsu_pkg::size_half_u: res.data = {16'h0, v[15:0]};
            default:              res.data = v;
        endcase
        res.tag = r.tag;
        res.hit_mask = got & need;
        res.full_hit = ((got & need) == need);
        return res;
    endfunction

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            compare("ld_resp_valid", 32'(ld_resp_valid), 32'(exp_pend));
            if (exp_pend && ld_resp_valid) begin
                compare("ld_resp.tag", 32'(ld_resp.tag), 32'(exp_resp.tag));
                compare("ld_resp.data", ld_resp.data, exp_resp.data);
                compare("ld_resp.hit_mask", 32'(ld_resp.hit_mask), 32'(exp_resp.hit_mask));
                compare("ld_resp.full_hit", 32'(ld_resp.full_hit), 32'(exp_resp.full_hit));
            end
            exp_pend = ld_pend;
            if (ld_pend) exp_resp = expect_load(ld_hold);
            ld_pend = ld_valid && !flush;  // Flush drops the decoded load
            ld_hold = ld_req;
            compare("drain_error", 32'(drain_error), 32'(err_seen));
            // Blocked only with a held store in decode and a full queue
            compare("st_ready", 32'(st_ready), 32'(model_q.size() <= sq_depth));
            if (prev_psel && !(prev_penable && prev_pready)) begin
                // Setup or access still waiting for pready
                compare("psel", 32'(psel), 32'h1);
                compare("penable", 32'(penable), 32'h1);
                compare("paddr", paddr, prev_paddr);
                compare("pwdata", pwdata, prev_pwdata);
                compare("pstrb", 32'(pstrb), 32'(prev_pstrb));
            end else begin
                compare("penable", 32'(penable), 32'h0);
                if (prev_psel) compare("psel", 32'(psel), 32'h0);  // Idle gap after a write
            end
            prev_psel = psel;
            prev_penable = penable;
            prev_pready = pready;
            prev_paddr = paddr;
            prev_pwdata = pwdata;
            prev_pstrb = pstrb;
            if (psel && penable && pready) begin
                if (cmt_left == 0) begin
                    errors++;
                    $display("APB write to %h with no committed store waiting", paddr);
                end else begin
                    compare("paddr", paddr, {model_q[0].waddr, 2'b00});
                    compare("pwdata", pwdata, model_q[0].data);
                    compare("pstrb", 32'(pstrb), 32'(model_q[0].byte_mask));
                    compare("pwrite", 32'(pwrite), 32'h1);
                    void'(model_q.pop_front());
                    cmt_left--;
                end
                if (pslverr) err_seen = 1'b1;
            end
            if (commit_valid) cmt_left++;
            if (flush) begin
                while (model_q.size() > cmt_left) void'(model_q.pop_back());
            end else if (st_valid && st_ready) begin
                model_q.push_back(place_store(st_req));
            end
        end
    end

    task automatic report(input int bench_errors);
        $display("Checks %0d, compare errors %0d, other errors %0d, stores left %0d",
                 checks, errors, bench_errors, model_q.size());
    endtask

endmodule

/* bench/tb_store_queue.sv */
`timescale 1ns/1ps

module tb_store_queue;

    logic                clk;
    logic                arst_n;
    logic                st_valid;
    logic                st_ready;
    lsu_pkg::store_req_t st_req;
    logic                ld_valid;
    lsu_pkg::load_req_t  ld_req;
    logic                ld_resp_valid;
    lsu_pkg::load_resp_t ld_resp;
    logic                commit_valid;
    logic                flush;
    lsu_pkg::addr_t      paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    lsu_pkg::word_t      pwdata;
    lsu_pkg::byte_mask_t pstrb;
    logic                pready;
    logic                pslverr;
    logic                drain_error;
    logic                stall;
    logic                stall_en;
    int                  err_index;
    int                  write_count;
    int                  tb_errors;
    logic [15:0]         lfsr;
    lsu_pkg::seq_tag_t   next_tag;

    clock_gen u_clk (.clk(clk));

    store_queue_top #(.sq_depth(8)) UUT (
        .clk(clk), .arst_n(arst_n), .st_valid(st_valid), .st_ready(st_ready),
        .st_req(st_req), .ld_valid(ld_valid), .ld_req(ld_req),
        .ld_resp_valid(ld_resp_valid), .ld_resp(ld_resp), .commit_valid(commit_valid),
        .flush(flush), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .pslverr(pslverr),
        .drain_error(drain_error)
    );

    apb_mem_model u_mem (
        .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .stall(stall),
        .err_index(err_index), .pready(pready), .pslverr(pslverr),
        .write_count(write_count)
    );

    sq_checker #(.sq_depth(8)) chk (
        .clk(clk), .arst_n(arst_n), .st_valid(st_valid), .st_ready(st_ready),
        .st_req(st_req), .ld_valid(ld_valid), .ld_req(ld_req),
        .ld_resp_valid(ld_resp_valid), .ld_resp(ld_resp), .commit_valid(commit_valid),
        .flush(flush), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .pslverr(pslverr),
        .drain_error(drain_error)
    );

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 16'hb400;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic lsu_pkg::seq_tag_t take_tag();
        lsu_pkg::seq_tag_t t;
        t = next_tag;
        next_tag = next_tag + 8'd1;
        return t;
    endfunction

    always @(negedge clk) begin
        stall <= stall_en && lfsr_bit();  // Random pready wait states
    end

    // Entered and left on a falling edge
    task automatic send_store(input lsu_pkg::addr_t a, input lsu_pkg::word_t d,
                              input lsu_pkg::mem_size_t s);
        int t;
        t = 0;
        st_valid = 1'b1;
        st_req = '{tag: take_tag(), addr: a, data: d, size: s};
        while (!st_ready && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (t >= 200) begin
            tb_errors++;
            $display("Timeout: store to %h was never accepted", a);
        end
        @(negedge clk);
        st_valid = 1'b0;
    endtask

    task automatic send_load(input lsu_pkg::seq_tag_t tg, input lsu_pkg::addr_t a,
                             input lsu_pkg::mem_size_t s);
        ld_valid = 1'b1;
        ld_req = '{tag: tg, addr: a, size: s};
        @(negedge clk);
        ld_valid = 1'b0;
    endtask

    task automatic commit_one();
        commit_valid = 1'b1;
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while ((chk.cmt_left != 0 || psel) && t < 500) begin
            @(negedge clk);
            t++;
        end
        if (t >= 500) begin
            tb_errors++;
            $display("Timeout: committed stores did not drain to APB");
        end
    endtask

    function automatic lsu_pkg::mem_size_t pick_size(logic [2:0] r);
        case (r)
            3'd0, 3'd5: return lsu_pkg::size_byte;
            3'd1, 3'd6: return lsu_pkg::size_half;
            3'd2, 3'd7: return lsu_pkg::size_word;
            3'd3:       return lsu_pkg::size_byte_u;
            default:    return lsu_pkg::size_half_u;
        endcase
    endfunction

    task automatic random_round();
        lsu_pkg::mem_size_t s;
        lsu_pkg::addr_t     a;
        int                 n;
        n = 1 + int'(rand_bits(2));
        for (int i = 0; i < n; i++) begin
            s = pick_size(3'(rand_bits(2)));
            a = 32'h300 + (rand_bits(2) << 2) + rand_bits(2);
            send_store(a & ((s == lsu_pkg::size_word) ? ~32'h3 : ~32'h0), rand_bits(32), s);
        end
        for (int i = 0; i < 2; i++) begin
            s = pick_size(3'(rand_bits(3)));
            a = 32'h300 + (rand_bits(2) << 2) + rand_bits(2);
            send_load(take_tag(), a, s);
        end
        repeat (n) commit_one();
        wait_drain();
    endtask

    initial begin
        lsu_pkg::seq_tag_t t_mid;
        int                t;
        lfsr = 16'd7;
        next_tag = 8'd0;
        tb_errors = 0;
        arst_n = 1'b0;
        st_valid = 1'b0;
        st_req = '0;
        ld_valid = 1'b0;
        ld_req = '0;
        commit_valid = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        stall_en = 1'b0;
        err_index = -1;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Full word forwarding and byte extraction at every offset
        send_store(32'h100, 32'h80ff_7f81, lsu_pkg::size_word);
        send_load(take_tag(), 32'h100, lsu_pkg::size_word);
        for (int k = 0; k < 4; k++) begin
            send_load(take_tag(), 32'h100 + k, lsu_pkg::size_byte);
            send_load(take_tag(), 32'h100 + k, lsu_pkg::size_byte_u);
        end
        commit_one();
        wait_drain();

        // Youngest older store wins per lane
        send_store(32'h200, 32'h1122_3344, lsu_pkg::size_half);
        send_store(32'h201, 32'h0000_00a5, lsu_pkg::size_byte);
        t_mid = take_tag();
        send_store(32'h202, 32'h0000_8899, lsu_pkg::size_half);
        send_store(32'h203, 32'h0000_00c3, lsu_pkg::size_byte);
        send_store(32'h212, 32'h0000_f00d, lsu_pkg::size_half);
        send_load(take_tag(), 32'h200, lsu_pkg::size_word);
        send_load(t_mid, 32'h200, lsu_pkg::size_word);
        send_load(take_tag(), 32'h210, lsu_pkg::size_word);
        send_load(take_tag(), 32'h202, lsu_pkg::size_half);
        repeat (5) commit_one();
        wait_drain();

        // Random traffic with wait states
        stall_en = 1'b1;
        repeat (12) random_round();

        // Fill the queue until back-pressure
        fork
            begin
                for (int k = 0; k < 10; k++) begin
                    send_store(32'h500 + 32'(4 * k), rand_bits(32), lsu_pkg::size_word);
                end
            end
            begin
                t = 0;
                while (st_ready && t < 60) begin
                    @(negedge clk);
                    t++;
                end
                if (t >= 60) begin
                    tb_errors++;
                    $display("Timeout: st_ready never went low with a full queue");
                end
                repeat (2) @(negedge clk);
                repeat (8) commit_one();
            end
        join
        repeat (2) @(negedge clk);
        repeat (2) commit_one();
        wait_drain();

        // Flush keeps committed stores and drops speculative ones
        send_store(32'h400, 32'hcafe_0001, lsu_pkg::size_word);
        send_store(32'h404, 32'hcafe_0002, lsu_pkg::size_word);
        @(negedge clk);
        commit_one();
        send_store(32'h400, 32'hdead_0003, lsu_pkg::size_word);
        pulse_flush();
        send_load(take_tag(), 32'h400, lsu_pkg::size_word);
        send_load(take_tag(), 32'h404, lsu_pkg::size_word);
        wait_drain();

        // Slave error on the second of three writes
        err_index = write_count + 1;
        for (int k = 0; k < 3; k++) begin
            send_store(32'h600 + 32'(4 * k), rand_bits(32), lsu_pkg::size_word);
        end
        @(negedge clk);
        repeat (3) commit_one();
        wait_drain();
        if (!drain_error) begin
            tb_errors++;
            $display("drain_error stayed low after a slave error");
        end

        repeat (3) @(negedge clk);
        chk.report(tb_errors);
        if (chk.errors + tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [29:0] word_addr_t;  // Byte address without the lane bits
    typedef logic [7:0]  seq_tag_t;    // Same tag space as the ROB
    typedef logic [3:0]  byte_mask_t;
    typedef logic [1:0]  byte_off_t;
    typedef logic [2:0]  mem_size_t;   // funct3 of the load/store

    localparam mem_size_t size_byte   = 3'b000;
    localparam mem_size_t size_half   = 3'b001;
    localparam mem_size_t size_word   = 3'b010;
    localparam mem_size_t size_byte_u = 3'b100;
    localparam mem_size_t size_half_u = 3'b101;

    typedef struct packed {
        seq_tag_t  tag;
        addr_t     addr;
        word_t     data;
        mem_size_t size;
    } store_req_t;

    typedef struct packed {
        seq_tag_t  tag;
        addr_t     addr;
        mem_size_t size;
    } load_req_t;

    typedef struct packed {
        seq_tag_t   tag;
        word_addr_t waddr;
        word_t      data;       // Already placed in its lanes
        byte_mask_t byte_mask;
    } sq_store_t;

    typedef struct packed {
        seq_tag_t   tag;
        word_addr_t waddr;
        byte_mask_t byte_mask;
        byte_off_t  offset;
        mem_size_t  size;
    } sq_load_t;

    typedef struct packed {
        seq_tag_t   tag;
        word_t      data;       // Extended by size
        byte_mask_t hit_mask;
        logic       full_hit;
    } load_resp_t;

endpackage

/* source/mem_req_decode.sv */
`timescale 1ns/1ps

module mem_req_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                st_valid,
    output logic                st_ready,
    input  lsu_pkg::store_req_t st_req,
    input  logic                ld_valid,
    input  lsu_pkg::load_req_t  ld_req,
    output logic                dec_st_valid,
    output lsu_pkg::sq_store_t  dec_st,
    input  logic                sq_ready,
    output logic                dec_ld_valid,
    output lsu_pkg::sq_load_t   dec_ld
);

    lsu_pkg::sq_store_t st_dec;
    lsu_pkg::sq_load_t  ld_dec;
    lsu_pkg::byte_off_t st_off;

    function automatic lsu_pkg::byte_off_t align_off(lsu_pkg::addr_t addr,
                                                     lsu_pkg::mem_size_t size);
        case (size)
            lsu_pkg::size_byte, lsu_pkg::size_byte_u: return addr[1:0];
            lsu_pkg::size_half, lsu_pkg::size_half_u: return {addr[1], 1'b0};
            default: return 2'b00;
        endcase
    endfunction

    function automatic lsu_pkg::byte_mask_t size_mask(lsu_pkg::mem_size_t size,
                                                      lsu_pkg::byte_off_t off);
        case (size)
            lsu_pkg::size_byte, lsu_pkg::size_byte_u: return 4'b0001 << off;
            lsu_pkg::size_half, lsu_pkg::size_half_u: return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    always_comb begin
        st_off           = align_off(st_req.addr, st_req.size);
        st_dec.tag       = st_req.tag;
        st_dec.waddr     = st_req.addr[31:2];
        st_dec.byte_mask = size_mask(st_req.size, st_off);
        case (st_req.size)  // Truncate, then move into the lanes
            lsu_pkg::size_byte, lsu_pkg::size_byte_u:
                st_dec.data = lsu_pkg::word_t'(st_req.data[7:0]) << {st_off, 3'b000};
            lsu_pkg::size_half, lsu_pkg::size_half_u:
                st_dec.data = lsu_pkg::word_t'(st_req.data[15:0]) << {st_off, 3'b000};
            default:
                st_dec.data = st_req.data;
        endcase
    end

    always_comb begin
        ld_dec.tag       = ld_req.tag;
        ld_dec.waddr     = ld_req.addr[31:2];
        ld_dec.offset    = align_off(ld_req.addr, ld_req.size);
        ld_dec.byte_mask = size_mask(ld_req.size, ld_dec.offset);
        ld_dec.size      = ld_req.size;
    end

    // Empty slot, or the queue takes the held store this cycle
    assign st_ready = !dec_st_valid || sq_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_st_valid <= 1'b0;
            dec_ld_valid <= 1'b0;
        end else if (flush) begin
            dec_st_valid <= 1'b0;
            dec_ld_valid <= 1'b0;
        end else begin
            if (st_ready) begin
                dec_st_valid <= st_valid;
            end
            dec_ld_valid <= ld_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (st_valid && st_ready) begin
            dec_st <= st_dec;
        end
        if (ld_valid) begin
            dec_ld <= ld_dec;
        end
    end

endmodule

/* source/store_drain_apb.sv */
`timescale 1ns/1ps

module store_drain_apb (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                drain_valid,
    input  lsu_pkg::sq_store_t  drain_entry,
    output logic                drain_pop,
    output lsu_pkg::addr_t      paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output lsu_pkg::word_t      pwdata,
    output lsu_pkg::byte_mask_t pstrb,
    input  logic                pready,
    input  logic                pslverr,
    output logic                drain_error
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } drain_state_t;

    drain_state_t state;
    drain_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (drain_valid) begin
                    state_nxt = st_setup;
                end
            end
            st_setup: state_nxt = st_access;
            st_access: begin
                if (pready) begin
                    state_nxt = st_idle;  // Idle gap before next transfer
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            drain_error <= 1'b0;
        end else begin
            state <= state_nxt;
            if (drain_pop && pslverr) begin
                drain_error <= 1'b1;  // Sticky
            end
        end
    end

    // Bus fields held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (state == st_idle && drain_valid) begin
            paddr  <= {drain_entry.waddr, 2'b00};
            pwdata <= drain_entry.data;
            pstrb  <= drain_entry.byte_mask;
        end
    end

    assign psel      = (state != st_idle);
    assign penable   = (state == st_access);
    assign pwrite    = 1'b1;  // Write-only master
    assign drain_pop = (state == st_access) && pready;

endmodule

/* source/store_queue.sv */
`timescale 1ns/1ps

module store_queue #(
    parameter int sq_depth = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                dec_st_valid,
    input  lsu_pkg::sq_store_t  dec_st,
    output logic                sq_ready,
    input  logic                dec_ld_valid,
    input  lsu_pkg::sq_load_t   dec_ld,
    input  logic                commit_valid,
    output logic                ld_resp_valid,
    output lsu_pkg::load_resp_t ld_resp,
    output logic                drain_valid,
    output lsu_pkg::sq_store_t  drain_entry,
    input  logic                drain_pop
);

    localparam int pw = $clog2(sq_depth);

    lsu_pkg::sq_store_t  entries [sq_depth];
    logic [pw:0]         head;     // Oldest entry, next to drain
    logic [pw:0]         cmt;      // First uncommitted entry
    logic [pw:0]         tail;     // Next free slot
    logic [pw:0]         count;
    logic [pw:0]         cmt_nxt;
    logic                alloc;
    lsu_pkg::word_t      fwd_data;
    lsu_pkg::byte_mask_t fwd_mask;
    lsu_pkg::word_t      shifted;
    lsu_pkg::load_resp_t resp;

    // Negative tag difference means a is older than b
    function automatic logic is_older(lsu_pkg::seq_tag_t a, lsu_pkg::seq_tag_t b);
        lsu_pkg::seq_tag_t diff;
        diff = a - b;
        return diff[7];
    endfunction

    assign count    = tail - head;
    assign sq_ready = !count[pw];  // MSB set only when all slots are used
    assign alloc    = dec_st_valid && sq_ready;
    assign cmt_nxt  = cmt + {{pw{1'b0}}, commit_valid};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head          <= '0;
            cmt           <= '0;
            tail          <= '0;
            ld_resp_valid <= 1'b0;
        end else begin
            head <= head + {{pw{1'b0}}, drain_pop};
            cmt  <= cmt_nxt;
            if (flush) begin
                tail <= cmt_nxt;  // Speculative stores are gone
            end else begin
                tail <= tail + {{pw{1'b0}}, alloc};
            end
            ld_resp_valid <= dec_ld_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entries[tail[pw-1:0]] <= dec_st;
        end
        if (dec_ld_valid) begin
            ld_resp <= resp;
        end
    end

    assign drain_valid = (head != cmt);
    assign drain_entry = entries[head[pw-1:0]];

    // Walk from oldest to youngest so younger stores overwrite per lane.
    // The store still held in decode is younger than every queued entry,
    // so it is checked last.
    always_comb begin : fwd_lookup
        logic [pw-1:0]      idx;
        lsu_pkg::sq_store_t cand;
        logic               cand_ok;
        idx      = '0;
        fwd_data = '0;
        fwd_mask = '0;
        for (int k = 0; k <= sq_depth; k++) begin
            if (k < sq_depth) begin
                idx     = head[pw-1:0] + pw'(k);
                cand    = entries[idx];
                cand_ok = (k < int'(count));
            end else begin
                cand    = dec_st;
                cand_ok = dec_st_valid;
            end
            if (cand_ok && cand.waddr == dec_ld.waddr && is_older(cand.tag, dec_ld.tag)) begin
                for (int b = 0; b < 4; b++) begin
                    if (cand.byte_mask[b]) begin
                        fwd_data[8*b +: 8] = cand.data[8*b +: 8];
                        fwd_mask[b]        = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        shifted       = fwd_data >> {dec_ld.offset, 3'b000};
        resp.tag      = dec_ld.tag;
        resp.hit_mask = fwd_mask & dec_ld.byte_mask;
        resp.full_hit = (resp.hit_mask == dec_ld.byte_mask);
        case (dec_ld.size)
            lsu_pkg::size_byte:   resp.data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::size_byte_u: resp.data = {24'h0, shifted[7:0]};
            lsu_pkg::size_half:   resp.data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::size_half_u: resp.data = {16'h0, shifted[15:0]};
            default:              resp.data = shifted;  // LW
        endcase
    end

endmodule

/* source/store_queue_top.sv */
`timescale 1ns/1ps

module store_queue_top #(
    parameter int sq_depth = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                st_valid,
    output logic                st_ready,
    input  lsu_pkg::store_req_t st_req,
    input  logic                ld_valid,
    input  lsu_pkg::load_req_t  ld_req,
    output logic                ld_resp_valid,
    output lsu_pkg::load_resp_t ld_resp,
    input  logic                commit_valid,
    input  logic                flush,
    output lsu_pkg::addr_t      paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output lsu_pkg::word_t      pwdata,
    output lsu_pkg::byte_mask_t pstrb,
    input  logic                pready,
    input  logic                pslverr,
    output logic                drain_error
);

    logic               dec_st_valid;
    lsu_pkg::sq_store_t dec_st;
    logic               sq_ready;
    logic               dec_ld_valid;
    lsu_pkg::sq_load_t  dec_ld;
    logic               drain_valid;
    lsu_pkg::sq_store_t drain_entry;
    logic               drain_pop;

    mem_req_decode u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .st_valid     (st_valid),
        .st_ready     (st_ready),
        .st_req       (st_req),
        .ld_valid     (ld_valid),
        .ld_req       (ld_req),
        .dec_st_valid (dec_st_valid),
        .dec_st       (dec_st),
        .sq_ready     (sq_ready),
        .dec_ld_valid (dec_ld_valid),
        .dec_ld       (dec_ld)
    );

    store_queue #(
        .sq_depth (sq_depth)
    ) u_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .dec_st_valid  (dec_st_valid),
        .dec_st        (dec_st),
        .sq_ready      (sq_ready),
        .dec_ld_valid  (dec_ld_valid),
        .dec_ld        (dec_ld),
        .commit_valid  (commit_valid),
        .ld_resp_valid (ld_resp_valid),
        .ld_resp       (ld_resp),
        .drain_valid   (drain_valid),
        .drain_entry   (drain_entry),
        .drain_pop     (drain_pop)
    );

    store_drain_apb u_drain (
        .clk         (clk),
        .arst_n      (arst_n),
        .drain_valid (drain_valid),
        .drain_entry (drain_entry),
        .drain_pop   (drain_pop),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .pready      (pready),
        .pslverr     (pslverr),
        .drain_error (drain_error)
    );

endmodule

/* store_queue_top.f */
source/lsu_pkg.sv
source/mem_req_decode.sv
source/store_queue.sv
source/store_drain_apb.sv
source/store_queue_top.sv
bench/clock_gen.sv
bench/apb_mem_model.sv
bench/sq_checker.sv
bench/tb_store_queue.sv
